// ==== hdl/cam_pkg.sv ====
`default_nettype none

package cam_pkg;

    localparam int PIXEL_BITS   = 10;
    localparam int WORD_BITS    = 32;
    localparam int FB_WORDS     = 256;
    localparam int FB_ADDR_BITS = 8;
    localparam int ACC_BITS     = 42;  // One partial word plus the widest pixel
    localparam int FILL_BITS    = 6;

    // Encoded as the pixel width in bits
    typedef enum logic [3:0] {
        FMT_GRAY4 = 4'd4,
        FMT_RGB8  = 4'd8,
        FMT_RGB10 = 4'd10
    } pixel_format_e;

    typedef struct packed {
        logic                  frame_valid;
        logic                  pixel_valid;
        logic [PIXEL_BITS-1:0] pixel;       // Narrow formats use the low bits
    } pixel_beat_t;

    typedef struct packed {
        logic                    we;
        logic [FB_ADDR_BITS-1:0] addr;
        logic [WORD_BITS-1:0]    data;
    } fb_write_t;

endpackage

`default_nettype wire

// ==== hdl/apb_pkg.sv ====
`default_nettype none

package apb_pkg;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [11:0] paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic        pready;
        logic        pslverr;
        logic [31:0] prdata;
    } apb_rsp_t;

    // Register map
    localparam logic [11:0] REG_CTRL   = 12'h000;  // [3:0] format, [4] enable
    localparam logic [11:0] REG_WORDS  = 12'h004;
    localparam logic [11:0] REG_FRAMES = 12'h008;
    localparam logic [11:0] FB_WINDOW  = 12'h400;

    typedef enum logic {
        APB_IDLE,
        APB_RAM_WAIT
    } apb_state_e;

endpackage

`default_nettype wire

// ==== hdl/pixel_packer.sv ====
`default_nettype none

module pixel_packer
    import cam_pkg::*;
(
    input  logic                  clock,
    input  logic                  rst,
    input  pixel_beat_t           cam,
    input  pixel_format_e         format,
    input  logic                  enable,
    output fb_write_t             fb_wr,
    output logic                  frame_done,
    output logic [FB_ADDR_BITS:0] frame_words
);

    logic                    in_frame;
    pixel_format_e           fmt_q;
    logic                    en_q;
    logic [ACC_BITS-1:0]     acc;
    logic [FILL_BITS-1:0]    fill;       // Valid bits at the low end of acc
    logic [FB_ADDR_BITS-1:0] wr_addr;
    logic [FB_ADDR_BITS:0]   word_cnt;

    logic                    wr_we;
    logic [FB_ADDR_BITS-1:0] wr_addr_q;
    logic [WORD_BITS-1:0]    wr_data;

    logic                    frame_start;
    logic                    frame_end;
    logic                    take;
    pixel_format_e           cur_fmt;
    logic [3:0]              width;
    logic [PIXEL_BITS-1:0]   pix_bits;
    logic [ACC_BITS-1:0]     acc_shift;
    logic [FILL_BITS-1:0]    fill_shift;
    logic                    word_full;
    logic [WORD_BITS-1:0]    full_word;
    logic [WORD_BITS-1:0]    tail_word;
    logic                    tail_pending;
    logic [FB_ADDR_BITS:0]   frame_total;

    assign frame_start = cam.frame_valid && !in_frame;
    assign frame_end   = in_frame && !cam.frame_valid;

    // First beat of a frame already uses the freshly sampled settings
    assign cur_fmt = frame_start ? format : fmt_q;
    assign take    = cam.frame_valid && cam.pixel_valid && (frame_start ? enable : en_q);
    assign width   = cur_fmt;

    assign pix_bits   = cam.pixel & ~({PIXEL_BITS{1'b1}} << width);
    assign acc_shift  = (acc << width) | ACC_BITS'(pix_bits);
    assign fill_shift = fill + FILL_BITS'(width);
    assign word_full  = fill_shift >= FILL_BITS'(WORD_BITS);

    // Oldest 32 bits sit just below the fill mark, anything above is stale
    assign full_word = WORD_BITS'(acc_shift >> (fill_shift - FILL_BITS'(WORD_BITS)));
    assign tail_word = WORD_BITS'(acc << (FILL_BITS'(WORD_BITS) - fill));  // Zero padded

    assign tail_pending = fill != '0;
    assign frame_total  = (tail_pending && word_cnt != FB_WORDS) ? word_cnt + 1'b1 : word_cnt;

    always_ff @(posedge clock) begin
        if (rst) begin
            in_frame    <= 1'b0;
            fmt_q       <= FMT_RGB8;
            en_q        <= 1'b0;
            fill        <= '0;
            wr_addr     <= '0;
            word_cnt    <= '0;
            wr_we       <= 1'b0;
            frame_done  <= 1'b0;
            frame_words <= '0;
        end else begin
            wr_we      <= 1'b0;
            frame_done <= 1'b0;
            in_frame   <= cam.frame_valid;

            if (frame_start) begin
                fmt_q <= format;
                en_q  <= enable;
            end

            if (take) begin
                if (word_full) begin
                    fill    <= fill_shift - FILL_BITS'(WORD_BITS);
                    wr_we   <= 1'b1;
                    wr_addr <= wr_addr + 1'b1;  // Wraps past FB_WORDS
                    if (word_cnt != FB_WORDS) begin
                        word_cnt <= word_cnt + 1'b1;
                    end
                end else begin
                    fill <= fill_shift;
                end
            end

            if (frame_end) begin
                wr_we      <= tail_pending;
                frame_done <= 1'b1;
                fill       <= '0;
                wr_addr    <= '0;
                word_cnt   <= '0;
                if (en_q) begin
                    frame_words <= frame_total;  // Disabled frames keep the old count
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (take) begin
            acc <= acc_shift;
        end
        if (take && word_full) begin
            wr_data   <= full_word;
            wr_addr_q <= wr_addr;
        end else if (frame_end) begin
            wr_data   <= tail_word;
            wr_addr_q <= wr_addr;
        end
    end

    assign fb_wr = '{we: wr_we, addr: wr_addr_q, data: wr_data};

endmodule

`default_nettype wire

// ==== hdl/frame_buffer.sv ====
`default_nettype none

module frame_buffer
    import cam_pkg::*;
(
    input  logic                    clock,
    input  fb_write_t               fb_wr,
    input  logic [FB_ADDR_BITS-1:0] rd_addr,
    output logic [WORD_BITS-1:0]    rd_data
);

    logic [WORD_BITS-1:0] mem [FB_WORDS];

    // Read during write to the same address returns the old word
    always_ff @(posedge clock) begin
        if (fb_wr.we) begin
            mem[fb_wr.addr] <= fb_wr.data;
        end
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== hdl/cam_apb_regs.sv ====
`default_nettype none

module cam_apb_regs
    import cam_pkg::*;
    import apb_pkg::*;
(
    input  logic                    clock,
    input  logic                    rst,
    input  apb_req_t                apb_req,
    output apb_rsp_t                apb_rsp,
    output pixel_format_e           format,
    output logic                    enable,
    input  logic                    frame_done,
    input  logic [FB_ADDR_BITS:0]   frame_words,
    output logic [FB_ADDR_BITS-1:0] rd_addr,
    input  logic [WORD_BITS-1:0]    rd_data
);

    apb_state_e            state;
    logic                  pready_q;
    logic                  pslverr_q;
    logic [31:0]           prdata_q;
    logic [FB_ADDR_BITS:0] words_q;
    logic [15:0]           frames_q;

    logic                  setup;
    logic                  is_win;
    logic [11:0]           win_offset;
    logic [3:0]            wr_fmt;
    logic                  fmt_ok;
    logic                  wr_err;
    logic [31:0]           rd_val;
    logic                  rd_err;

    assign setup      = apb_req.psel && !apb_req.penable;
    assign is_win     = apb_req.paddr >= FB_WINDOW && apb_req.paddr < FB_WINDOW + 4 * FB_WORDS;
    assign win_offset = apb_req.paddr - FB_WINDOW;
    assign rd_addr    = win_offset[FB_ADDR_BITS+1:2];  // Word index, RAM read starts in setup

    assign wr_fmt = apb_req.pwdata[3:0];
    assign fmt_ok = wr_fmt == FMT_GRAY4 || wr_fmt == FMT_RGB8 || wr_fmt == FMT_RGB10;
    assign wr_err = apb_req.paddr != REG_CTRL || !fmt_ok;  // Only CTRL is writable

    always_comb begin
        rd_val = '0;
        rd_err = 1'b0;
        case (apb_req.paddr)
            REG_CTRL:   rd_val = {27'b0, enable, format};
            REG_WORDS:  rd_val = 32'(words_q);
            REG_FRAMES: rd_val = 32'(frames_q);
            default:    rd_err = 1'b1;
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            state     <= APB_IDLE;
            pready_q  <= 1'b0;
            pslverr_q <= 1'b0;
            format    <= FMT_RGB8;
            enable    <= 1'b0;
            words_q   <= '0;
            frames_q  <= '0;
        end else begin
            pready_q  <= 1'b0;
            pslverr_q <= 1'b0;

            if (frame_done) begin
                words_q  <= frame_words;
                frames_q <= frames_q + 1'b1;
            end

            case (state)
                APB_IDLE: begin
                    if (setup) begin
                        if (is_win && !apb_req.pwrite) begin
                            state <= APB_RAM_WAIT;
                        end else if (apb_req.pwrite) begin
                            pready_q  <= 1'b1;
                            pslverr_q <= wr_err;
                            if (!wr_err) begin
                                format <= pixel_format_e'(wr_fmt);
                                enable <= apb_req.pwdata[4];
                            end
                        end else begin
                            pready_q  <= 1'b1;
                            pslverr_q <= rd_err;
                        end
                    end
                end
                APB_RAM_WAIT: begin
                    pready_q <= 1'b1;  // RAM data is valid now
                    state    <= APB_IDLE;
                end
                default: state <= APB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == APB_RAM_WAIT) begin
            prdata_q <= rd_data;
        end else if (setup) begin
            prdata_q <= rd_val;
        end
    end

    assign apb_rsp = '{pready: pready_q, pslverr: pslverr_q, prdata: prdata_q};

endmodule

`default_nettype wire

// ==== hdl/camera_capture_top.sv ====
`default_nettype none

module camera_capture_top
    import cam_pkg::*;
    import apb_pkg::*;
(
    input  logic        clock,
    input  logic        rst,
    input  pixel_beat_t cam,
    input  apb_req_t    apb_req,
    output apb_rsp_t    apb_rsp
);

    pixel_format_e           format;
    logic                    enable;
    fb_write_t               fb_wr;
    logic                    frame_done;
    logic [FB_ADDR_BITS:0]   frame_words;
    logic [FB_ADDR_BITS-1:0] rd_addr;
    logic [WORD_BITS-1:0]    rd_data;

    pixel_packer u_pixel_packer (
        .clock       (clock),
        .rst         (rst),
        .cam         (cam),
        .format      (format),
        .enable      (enable),
        .fb_wr       (fb_wr),
        .frame_done  (frame_done),
        .frame_words (frame_words)
    );

    frame_buffer u_frame_buffer (
        .clock   (clock),
        .fb_wr   (fb_wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    // Register block and readback window
    cam_apb_regs u_cam_apb_regs (
        .clock       (clock),
        .rst         (rst),
        .apb_req     (apb_req),
        .apb_rsp     (apb_rsp),
        .format      (format),
        .enable      (enable),
        .frame_done  (frame_done),
        .frame_words (frame_words),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data)
    );

endmodule

`default_nettype wire

// ==== dv/cam_tb_model.svh ====
`ifndef CAM_TB_MODEL_SVH
`define CAM_TB_MODEL_SVH

typedef logic [WORD_BITS-1:0]  word_q_t[$];
typedef logic [PIXEL_BITS-1:0] pix_q_t[$];

// MSB first, pixels spill into the next word, zero padded tail
function automatic word_q_t pack_frame(input pixel_format_e fmt, input pix_q_t pix);
    word_q_t              words;
    logic [WORD_BITS-1:0] cur;
    int                   pos;
    cur = '0;
    pos = 0;
    foreach (pix[i]) begin
        for (int b = int'(fmt) - 1; b >= 0; b--) begin
            cur[WORD_BITS-1-pos] = pix[i][b];
            pos++;
            if (pos == WORD_BITS) begin
                words.push_back(cur);
                cur = '0;
                pos = 0;
            end
        end
    end
    if (pos != 0)
        words.push_back(cur);
    return words;
endfunction

function automatic pix_q_t random_pixels(input int n);
    pix_q_t pix;
    repeat (n) pix.push_back(PIXEL_BITS'($urandom));  // Upper bits must be ignored
    return pix;
endfunction

function automatic logic [31:0] ctrl_word(input pixel_format_e fmt, input logic en);
    return {27'b0, en, fmt};
endfunction

task automatic apb_xfer(input logic write, input logic [11:0] addr, input logic [31:0] wdata,
                        output logic [31:0] rdata, output logic err);
    int waits;
    @(posedge clock);
    #2;
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
    @(posedge clock);
    #2;
    apb_req.penable = 1'b1;
    waits = 0;
    @(negedge clock);
    while (!apb_rsp.pready) begin
        waits++;
        if (waits > 8)
            abort_run("APB transfer never completed, pready stayed low");
        @(negedge clock);
    end
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    @(posedge clock);
    #2;
    apb_req = '0;
endtask

task automatic apb_write(input logic [11:0] addr, input logic [31:0] wdata, output logic err);
    logic [31:0] unused;
    apb_xfer(1'b1, addr, wdata, unused, err);
endtask

task automatic apb_read(input logic [11:0] addr, output logic [31:0] rdata, output logic err);
    apb_xfer(1'b0, addr, '0, rdata, err);
endtask

task automatic check_word(input string name, input logic [WORD_BITS-1:0] exp,
                          input logic [WORD_BITS-1:0] act);
    if (act !== exp)
        abort_run($sformatf("FAILED %s expected 0x%08h actual 0x%08h", name, exp, act));
endtask

task automatic check_count(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp)
        abort_run($sformatf("FAILED %s expected 0x%0h actual 0x%0h", name, exp, act));
endtask

task automatic check_err(input string name, input logic exp, input logic act);
    if (act !== exp)
        abort_run($sformatf("FAILED %s expected 0x%0h actual 0x%0h", name, exp, act));
endtask

task automatic check_ctrl(input pixel_format_e fmt, input logic en, input logic [31:0] act);
    if (act !== ctrl_word(fmt, en))
        abort_run($sformatf("FAILED CTRL expected 0x%08h actual 0x%08h", ctrl_word(fmt, en), act));
endtask

`endif

// ==== dv/tb_camera_capture.sv ====
`default_nettype none

module tb_camera_capture
    import cam_pkg::*;
    import apb_pkg::*;
();

    localparam int RGB8_FRAMES = 6;

    logic        clock;
    logic        rst;
    pixel_beat_t cam;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    int          cycles = 0;
    int          cycle_limit = 0;
    logic        check_req = 1'b0;  // Frame handed to the scoreboard

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped");
    endtask

    `include "cam_tb_model.svh"

    word_q_t     exp_words;
    logic [31:0] exp_count;
    int          exp_frames;

    initial clock = 1'b0;
    always #10 clock = ~clock;

    camera_capture_top u_camera_capture_top (
        .clock   (clock),
        .rst     (rst),
        .cam     (cam),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit)
            abort_run($sformatf("Timeout, the run did not finish within %0d cycles", cycle_limit));
    end

    task automatic drive_frame(input pix_q_t pix, input int max_gap);
        foreach (pix[i]) begin
            repeat ($urandom_range(max_gap, 0)) begin
                @(posedge clock);
                #2;
                cam = '{frame_valid: 1'b1, pixel_valid: 1'b0, pixel: PIXEL_BITS'($urandom)};
            end
            @(posedge clock);
            #2;
            cam = '{frame_valid: 1'b1, pixel_valid: 1'b1, pixel: pix[i]};
        end
        @(posedge clock);
        #2;
        cam = '0;
    endtask

    // Disabled frames keep the previous words and count
    task automatic expect_frame(input pixel_format_e fmt, input pix_q_t pix, input logic en);
        exp_frames++;
        if (en) begin
            exp_words = pack_frame(fmt, pix);
            exp_count = 32'(exp_words.size());
        end
        check_req = 1'b1;
        wait (!check_req);
    endtask

    initial begin : scoreboard
        logic [31:0] rdata;
        logic        err;
        int          polls;
        forever begin
            wait (check_req);
            polls = 0;
            apb_read(REG_FRAMES, rdata, err);
            while (rdata < 32'(exp_frames)) begin
                polls++;
                if (polls > 10)
                    abort_run("REG_FRAMES never reached the number of frames sent");
                apb_read(REG_FRAMES, rdata, err);
            end
            check_count("REG_FRAMES", 32'(exp_frames), rdata);
            apb_read(REG_WORDS, rdata, err);
            check_count("REG_WORDS", exp_count, rdata);
            foreach (exp_words[i]) begin
                apb_read(FB_WINDOW + 12'(4 * i), rdata, err);
                check_err("pslverr", 1'b0, err);
                check_word($sformatf("fb_word[%0d]", i), exp_words[i], rdata);
            end
            check_req = 1'b0;
        end
    end

    initial begin : stimulus
        logic [31:0] rdata;
        logic        err;
        pix_q_t      pix;
        int          lens [RGB8_FRAMES];
        int          frame_cycles;
        void'($urandom(33));
        frame_cycles = 16 + 13 + 24 + 2 * 20 + 10 + 5 * 2;
        foreach (lens[i]) begin
            lens[i] = $urandom_range(60, 1);
            frame_cycles += 3 * lens[i] + 2;  // Up to two idle beats per pixel
        end
        // At most five cycles per transfer, one readback per pixel plus register polls
        cycle_limit = 4 * (frame_cycles + 5 * (frame_cycles + 8 * (RGB8_FRAMES + 5) + 10)) + 2000;
        rst        = 1'b1;
        cam        = '0;
        apb_req    = '0;
        exp_frames = 0;
        exp_count  = '0;
        repeat (8) @(posedge clock);
        #2;
        rst = 1'b0;

        apb_read(REG_CTRL, rdata, err);
        check_err("pslverr", 1'b0, err);
        check_ctrl(FMT_RGB8, 1'b0, rdata);
        apb_read(REG_WORDS, rdata, err);
        check_count("REG_WORDS", '0, rdata);
        apb_read(REG_FRAMES, rdata, err);
        check_count("REG_FRAMES", '0, rdata);

        apb_write(REG_CTRL, ctrl_word(FMT_GRAY4, 1'b1), err);
        check_err("pslverr", 1'b0, err);
        pix = random_pixels(16);
        drive_frame(pix, 0);
        expect_frame(FMT_GRAY4, pix, 1'b1);
        apb_read(REG_WORDS, rdata, err);
        check_count("REG_WORDS", 32'd2, rdata);

        apb_write(REG_CTRL, ctrl_word(FMT_RGB10, 1'b1), err);
        pix = random_pixels(13);
        drive_frame(pix, 0);
        expect_frame(FMT_RGB10, pix, 1'b1);
        apb_read(REG_WORDS, rdata, err);
        check_count("REG_WORDS", 32'd5, rdata);

        apb_write(REG_CTRL, ctrl_word(FMT_RGB8, 1'b1), err);
        foreach (lens[i]) begin
            pix = random_pixels(lens[i]);
            drive_frame(pix, 2);
            expect_frame(FMT_RGB8, pix, 1'b1);
        end

        // Format written mid frame only applies to the next one
        pix = random_pixels(24);
        fork
            drive_frame(pix, 0);
            begin
                repeat (6) @(posedge clock);
                apb_write(REG_CTRL, ctrl_word(FMT_GRAY4, 1'b1), err);
            end
        join
        expect_frame(FMT_RGB8, pix, 1'b1);
        pix = random_pixels(20);
        drive_frame(pix, 1);
        expect_frame(FMT_GRAY4, pix, 1'b1);
        apb_write(REG_CTRL, ctrl_word(FMT_RGB10, 1'b0), err);
        pix = random_pixels(10);
        drive_frame(pix, 0);
        expect_frame(FMT_RGB10, pix, 1'b0);

        apb_read(12'h00C, rdata, err);
        check_err("pslverr", 1'b1, err);
        apb_read(REG_CTRL, rdata, err);
        check_ctrl(FMT_RGB10, 1'b0, rdata);
        apb_write(REG_WORDS, 32'h0000_0055, err);
        check_err("pslverr", 1'b1, err);
        apb_read(REG_CTRL, rdata, err);
        check_ctrl(FMT_RGB10, 1'b0, rdata);
        apb_write(REG_CTRL, 32'h0000_0016, err);  // Format 6 with enable
        check_err("pslverr", 1'b1, err);
        apb_read(REG_CTRL, rdata, err);
        check_ctrl(FMT_RGB10, 1'b0, rdata);

        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+dv
hdl/cam_pkg.sv
hdl/apb_pkg.sv
hdl/pixel_packer.sv
hdl/frame_buffer.sv
hdl/cam_apb_regs.sv
hdl/camera_capture_top.sv
dv/tb_camera_capture.sv

// ==== Bender.yml ====
package:
  name: camera_capture

sources:
  - hdl/cam_pkg.sv
  - hdl/apb_pkg.sv
  - hdl/pixel_packer.sv
  - hdl/frame_buffer.sv
  - hdl/cam_apb_regs.sv
  - hdl/camera_capture_top.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/tb_camera_capture.sv
